// File: cpu_pkg.sv
// CPU package: widths, opcodes, no-op word and the instruction views
package cpu_pkg;

   localparam int word_w     = 16;        // Data and PC width
   localparam int reg_addr_w = 4;         // Register index width
   localparam int op_w       = 4;         // Opcode field width

   // Bubble loaded into IF/ID on a hazard
   localparam logic [word_w-1:0] nop_word = 16'hF000;

   // Return address of CALL lands here
   localparam logic [reg_addr_w-1:0] link_reg = 4'd15;

   // Opcode encodings
   typedef enum logic [op_w-1:0] {
      op_add  = 4'h0,
      op_sub  = 4'h1,
      op_and  = 4'h2,
      op_or   = 4'h3,
      op_addi = 4'h4,                     // rd = rs + imm4
      op_ldi  = 4'h5,                     // rd = imm8
      op_call = 4'h6,                     // r15 = PC+1, jump
      op_nop  = 4'hF                      // Also stands for unused codes
   } alu_op_e;

   // One instruction word, three ways to read it
   typedef union packed {
      // Register format
      struct packed {
         logic [op_w-1:0]       opcode;
         logic [reg_addr_w-1:0] rd;
         logic [reg_addr_w-1:0] rs;
         logic [reg_addr_w-1:0] rt;       // Same bits as imm4 of ADDI
      } r;

      // Immediate format
      struct packed {
         logic [op_w-1:0]       opcode;
         logic [reg_addr_w-1:0] rd;
         logic [7:0]            imm8;
      } i;

      // Call format
      struct packed {
         logic [op_w-1:0] opcode;
         logic [11:0]     target;         // Low 12 bits of jump address
      } c;
   } instr_u;

endpackage

// File: pipe_if.sv
// Stage-to-stage buses of the pipeline, IF/ID to decode and decode to execute

interface fetch_decode_if;
   logic [cpu_pkg::op_w-1:0]       opcode;
   logic [cpu_pkg::reg_addr_w-1:0] rd;
   logic [cpu_pkg::reg_addr_w-1:0] rs;
   logic [cpu_pkg::reg_addr_w-1:0] rt;
   logic [3:0]                     imm4;
   logic [7:0]                     imm8;
   logic [11:0]                    target;
   logic [cpu_pkg::word_w-1:0]     pc;           // PC of the word in IF/ID
   logic                           redirect;     // CALL seen in decode
   logic [cpu_pkg::word_w-1:0]     redirect_pc;

   modport ifid   (output opcode, rd, rs, rt, imm4, imm8, target, pc, input redirect);
   modport decode (input opcode, rd, rs, rt, imm4, imm8, target, pc,
                   output redirect, redirect_pc);
   modport fetch  (input redirect, redirect_pc);
endinterface

interface decode_exec_if;
   // ID/EX register contents
   logic                           valid;
   cpu_pkg::alu_op_e               op;
   logic [cpu_pkg::reg_addr_w-1:0] rd;
   logic [cpu_pkg::word_w-1:0]     operand_a;
   logic [cpu_pkg::word_w-1:0]     operand_b;
   logic [cpu_pkg::word_w-1:0]     pc;

   // Write-back path, back toward decode
   logic                           wb_en;
   logic [cpu_pkg::reg_addr_w-1:0] wb_addr;
   logic [cpu_pkg::word_w-1:0]     wb_data;

   modport decode  (output valid, op, rd, operand_a, operand_b, pc,
                    input wb_en, wb_addr, wb_data);
   modport execute (input valid, op, rd, operand_a, operand_b, pc,
                    output wb_en, wb_addr, wb_data);
endinterface

// File: fetch_unit.sv
// Fetch stage: program counter with stall hold and CALL redirect
module fetch_unit (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       mem_wait,   // Instruction memory not ready
   fetch_decode_if.fetch              fd,
   output logic [cpu_pkg::word_w-1:0] imem_addr
);

   logic [cpu_pkg::word_w-1:0] pc;
   logic [cpu_pkg::word_w-1:0] pc_next;

   // Next PC select
   // Redirect wins over a stall, the word behind CALL is dropped anyway
   always_comb begin
      if (fd.redirect) begin
         pc_next = fd.redirect_pc;                // Jump to CALL target
      end else if (mem_wait) begin
         pc_next = pc;                            // Hold until memory ready
      end else begin
         pc_next = pc + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;                                // Start at address 0
      end else begin
         pc <= pc_next;
      end
   end

   // ROM is combinational, address straight from the register
   assign imem_addr = pc;

endmodule

// File: ifid_reg.sv
// IF/ID pipeline register: splits the instruction word, loads a bubble on hazard
module ifid_reg (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [cpu_pkg::word_w-1:0] instr,     // Word from instruction memory
   input  logic [cpu_pkg::word_w-1:0] pc_in,     // Address it was fetched from
   input  logic                       mem_wait,
   fetch_decode_if.ifid               fd
);

   logic             hazard;
   cpu_pkg::instr_u  word;                       // Word about to be latched

   // Stall from memory or squash behind a CALL
   assign hazard = mem_wait | fd.redirect;

   // Bubble replaces the fetched word on reset or hazard
   always_comb begin
      if (rst || hazard) begin
         word = cpu_pkg::nop_word;
      end else begin
         word = instr;
      end
   end

   // Field split through the union views
   always_ff @(posedge clk) begin
      fd.opcode <= word.r.opcode;
      fd.rd     <= word.r.rd;
      fd.rs     <= word.r.rs;
      fd.rt     <= word.r.rt;
      fd.imm4   <= word.r.rt;                     // Arithmetic immediate
      fd.imm8   <= word.i.imm8;
      fd.target <= word.c.target;
   end

   // PC of the word, frozen while a bubble goes in
   always_ff @(posedge clk) begin
      if (rst) begin
         fd.pc <= '0;
      end else if (!hazard) begin
         fd.pc <= pc_in;
      end
   end

endmodule

// File: decode_stage.sv
// Decode stage: register file, write-back bypass, CALL redirect and ID/EX register
module decode_stage (
   input  logic           clk,
   input  logic           rst,
   fetch_decode_if.decode fd,
   decode_exec_if.decode  dx
);

   // 16 x 16 register file
   logic [cpu_pkg::word_w-1:0] regs [16];

   logic [cpu_pkg::word_w-1:0] rs_val;           // Operand a after bypass
   logic [cpu_pkg::word_w-1:0] rt_val;
   logic [cpu_pkg::word_w-1:0] opnd_b;
   logic [cpu_pkg::word_w-1:0] pc_inc;           // Return address for CALL
   logic                       is_exec;          // Opcode does real work
   cpu_pkg::alu_op_e           op;

   // Written at the edge that ends the execute cycle
   always_ff @(posedge clk) begin
      if (dx.wb_en) begin
         regs[dx.wb_addr] <= dx.wb_data;
      end
   end

   // Result of the instruction just ahead is not in the file yet
   assign rs_val = (dx.wb_en && dx.wb_addr == fd.rs) ? dx.wb_data : regs[fd.rs];
   assign rt_val = (dx.wb_en && dx.wb_addr == fd.rt) ? dx.wb_data : regs[fd.rt];

   assign pc_inc = fd.pc + 16'd1;

   // Opcode check and operand b select
   always_comb begin
      is_exec = 1'b1;
      op      = cpu_pkg::alu_op_e'(fd.opcode);
      case (fd.opcode)
         cpu_pkg::op_add,
         cpu_pkg::op_sub,
         cpu_pkg::op_and,
         cpu_pkg::op_or: begin
            opnd_b = rt_val;                     // Register group
         end
         cpu_pkg::op_addi: begin
            opnd_b = {12'd0, fd.imm4};           // Zero-extended imm4
         end
         cpu_pkg::op_ldi: begin
            opnd_b = {8'd0, fd.imm8};            // Zero-extended imm8
         end
         cpu_pkg::op_call: begin
            opnd_b = pc_inc;                     // Link value
         end
         default: begin
            // F and unused codes do nothing
            is_exec = 1'b0;
            op      = cpu_pkg::op_nop;
            opnd_b  = rt_val;
         end
      endcase
   end

   // CALL redirects fetch in the cycle it sits in IF/ID
   assign fd.redirect    = (fd.opcode == cpu_pkg::op_call);
   assign fd.redirect_pc = {fd.pc[15:12], fd.target}; // Page of the CALL kept

   // ID/EX valid bit
   always_ff @(posedge clk) begin
      if (rst) begin
         dx.valid <= 1'b0;
      end else begin
         dx.valid <= is_exec;                    // No write-back for bubbles
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      dx.op        <= op;
      dx.rd        <= fd.rd;
      dx.operand_a <= rs_val;
      dx.operand_b <= opnd_b;
      dx.pc        <= fd.pc;
   end

endmodule

// File: execute_stage.sv
// Execute stage: ALU on the ID/EX contents and the write-back port
module execute_stage (
   input  logic                           clk,
   input  logic                           rst,
   decode_exec_if.execute                 dx,
   output logic                           wb_en,
   output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
   output logic [cpu_pkg::word_w-1:0]     wb_data
);

   logic [cpu_pkg::word_w-1:0]     result;
   logic [cpu_pkg::reg_addr_w-1:0] dest;

   // ALU
   always_comb begin
      case (dx.op)
         cpu_pkg::op_add,
         cpu_pkg::op_addi: result = dx.operand_a + dx.operand_b;
         cpu_pkg::op_sub:  result = dx.operand_a - dx.operand_b;
         cpu_pkg::op_and:  result = dx.operand_a & dx.operand_b;
         cpu_pkg::op_or:   result = dx.operand_a | dx.operand_b;
         cpu_pkg::op_ldi,
         cpu_pkg::op_call: result = dx.operand_b; // Immediate or link value
         default:          result = dx.operand_b;
      endcase
   end

   // CALL always links into r15
   assign dest = (dx.op == cpu_pkg::op_call) ? cpu_pkg::link_reg : dx.rd;

   // Top-level copies
   assign wb_en   = dx.valid;                     // Every valid op writes
   assign wb_addr = dest;
   assign wb_data = result;

   // Same values back to decode
   assign dx.wb_en   = wb_en;
   assign dx.wb_addr = wb_addr;
   assign dx.wb_data = wb_data;

endmodule

// File: cpu_top.sv
// Three-stage 16-bit CPU core: fetch, decode and execute with plain outside ports
module cpu_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cpu_pkg::word_w-1:0]     instr,      // From combinational ROM
   input  logic                           mem_wait,   // ROM not ready
   output logic [cpu_pkg::word_w-1:0]     imem_addr,
   output logic                           wb_en,
   output logic [cpu_pkg::reg_addr_w-1:0] wb_addr,
   output logic [cpu_pkg::word_w-1:0]     wb_data
);

   // Stage buses
   fetch_decode_if fd_bus ();
   decode_exec_if  dx_bus ();

   // Program counter
   fetch_unit u_fetch (
      .clk       (clk),
      .rst       (rst),
      .mem_wait  (mem_wait),
      .fd        (fd_bus),
      .imem_addr (imem_addr)
   );

   // IF/ID register, latches the word at the current PC
   ifid_reg u_ifid (
      .clk      (clk),
      .rst      (rst),
      .instr    (instr),
      .pc_in    (imem_addr),
      .mem_wait (mem_wait),
      .fd       (fd_bus)
   );

   // Register read, bypass and ID/EX
   decode_stage u_decode (
      .clk (clk),
      .rst (rst),
      .fd  (fd_bus),
      .dx  (dx_bus)
   );

   // ALU and write-back
   execute_stage u_exec (
      .clk     (clk),
      .rst     (rst),
      .dx      (dx_bus),
      .wb_en   (wb_en),
      .wb_addr (wb_addr),
      .wb_data (wb_data)
   );

endmodule

// File: tb_clock.sv
// Testbench clock and power-on reset generator for the CPU core
module tb_clock (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int half_period = 5;          // 10 ns clock

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // Reset held over the first two rising edges
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);                       // Released away from the sampling edge
      rst = 1'b0;
   end

endmodule

// File: cpu_sva.sv
// Concurrent checks on fetch, redirect and write-back behavior of the CPU core
module cpu_sva (
   input logic                           clk,
   input logic                           rst,
   input logic                           mem_wait,
   input logic                           redirect,     // CALL in IF/ID
   input logic [cpu_pkg::word_w-1:0]     redirect_pc,
   input logic [cpu_pkg::word_w-1:0]     imem_addr,
   input logic                           wb_en,
   input logic [cpu_pkg::reg_addr_w-1:0] wb_addr
);
   timeunit 1ns;
   timeprecision 100ps;

   int assert_fails = 0;                    // Read by the testbench at the end

   // Pipeline is empty right after reset
   wb_quiet_after_rst: assert property (@(posedge clk) $fell(rst) |-> !wb_en ##1 !wb_en)
      else begin
         $error("wb_en high within two cycles of reset release");
         assert_fails++;
      end

   // Stall holds the PC
   pc_hold_on_wait: assert property (@(posedge clk) disable iff (rst)
      (mem_wait && !redirect) |=> $stable(imem_addr))
      else begin
         $error("imem_addr moved during a memory stall");
         assert_fails++;
      end

   // CALL target reaches fetch one edge later
   pc_follows_redirect: assert property (@(posedge clk) disable iff (rst)
      redirect |=> (imem_addr == $past(redirect_pc)))
      else begin
         $error("imem_addr does not match redirect_pc after a redirect");
         assert_fails++;
      end

   wb_addr_known: assert property (@(posedge clk) wb_en |-> !$isunknown(wb_addr))
      else begin
         $error("wb_addr unknown while wb_en is high");
         assert_fails++;
      end

endmodule

bind cpu_top cpu_sva u_sva (
   .clk         (clk),
   .rst         (rst),
   .mem_wait    (mem_wait),
   .redirect    (fd_bus.redirect),
   .redirect_pc (fd_bus.redirect_pc),
   .imem_addr   (imem_addr),
   .wb_en       (wb_en),
   .wb_addr     (wb_addr)
);

// File: cpu_tb.sv
// Testbench for the CPU core: program ROM, random stalls, write-back checks, watchdog
module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          prog_len        = 18;
   localparam int          clk_period      = 10;
   localparam int          watchdog_cycles = prog_len * 8 + 50;
   localparam logic [15:0] lfsr_seed       = 16'd30939;

   // One program word and the write-back it must produce
   typedef struct {
      string           name;
      cpu_pkg::instr_u word;
      bit              writes;              // Low for no-ops and skipped words
      logic [3:0]      rd;
      logic [15:0]     value;
   } entry_t;

   entry_t prog [prog_len];

   logic        clk;
   logic        por_rst;
   logic        rst;
   logic [15:0] instr;
   logic        mem_wait;
   logic [15:0] imem_addr;
   logic        wb_en;
   logic [3:0]  wb_addr;
   logic [15:0] wb_data;

   bit          rerun_rst = 1'b0;
   bit          stall_en  = 1'b0;           // mem_wait from the LFSR when set
   logic [15:0] lfsr      = lfsr_seed;
   int          run_no    = 1;
   int          exp_idx   = 0;              // Next table entry to match
   int          exp_total = 0;              // Write-backs per run
   int          seen      = 0;
   int          pass_cnt  = 0;
   int          fail_cnt  = 0;

   tb_clock clkgen (
      .clk (clk),
      .rst (por_rst)
   );

   assign rst = por_rst | rerun_rst;        // Second reset starts the stalled run

   cpu_top uut (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .mem_wait  (mem_wait),
      .imem_addr (imem_addr),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data)
   );

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Instruction builders through the union views
   function automatic cpu_pkg::instr_u r_fmt(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs, input logic [3:0] rt);
      cpu_pkg::instr_u w;
      w.r.opcode = op;
      w.r.rd     = rd;
      w.r.rs     = rs;
      w.r.rt     = rt;                      // imm4 for ADDI
      return w;
   endfunction

   function automatic cpu_pkg::instr_u i_fmt(input logic [3:0] rd, input logic [7:0] imm8);
      cpu_pkg::instr_u w;
      w.i.opcode = cpu_pkg::op_ldi;
      w.i.rd     = rd;
      w.i.imm8   = imm8;
      return w;
   endfunction

   function automatic cpu_pkg::instr_u c_fmt(input logic [11:0] target);
      cpu_pkg::instr_u w;
      w.c.opcode = cpu_pkg::op_call;
      w.c.target = target;
      return w;
   endfunction

   // Program at address 0, expected results from the ISA rules
   task automatic load_program();
      prog[0]  = '{"ldi_r1", i_fmt(4'd1, 8'h12), 1, 4'd1, 16'h0012};
      prog[1]  = '{"ldi_r2", i_fmt(4'd2, 8'h34), 1, 4'd2, 16'h0034};
      prog[2]  = '{"ldi_r3_zext", i_fmt(4'd3, 8'hF0), 1, 4'd3, 16'h00F0};
      prog[3]  = '{"nop", cpu_pkg::nop_word, 0, 4'd0, 16'h0000};
      prog[4]  = '{"ldi_r5", i_fmt(4'd5, 8'hC5), 1, 4'd5, 16'h00C5};
      prog[5]  = '{"add_fwd", r_fmt(cpu_pkg::op_add, 4'd4, 4'd5, 4'd2), 1, 4'd4, 16'h00F9};
      prog[6]  = '{"sub_fwd", r_fmt(cpu_pkg::op_sub, 4'd6, 4'd4, 4'd1), 1, 4'd6, 16'h00E7};
      prog[7]  = '{"and_fwd", r_fmt(cpu_pkg::op_and, 4'd7, 4'd6, 4'd3), 1, 4'd7, 16'h00E0};
      prog[8]  = '{"or_fwd", r_fmt(cpu_pkg::op_or, 4'd8, 4'd7, 4'd1), 1, 4'd8, 16'h00F2};
      prog[9]  = '{"sub_wrap", r_fmt(cpu_pkg::op_sub, 4'd9, 4'd1, 4'd8), 1, 4'd9, 16'hFF20};
      prog[10] = '{"unused_op", r_fmt(4'h8, 4'd1, 4'd2, 4'd3), 0, 4'd0, 16'h0000};
      prog[11] = '{"addi_7", r_fmt(cpu_pkg::op_addi, 4'd10, 4'd9, 4'd7), 1, 4'd10, 16'hFF27};
      prog[12] = '{"addi_f", r_fmt(cpu_pkg::op_addi, 4'd11, 4'd10, 4'hF), 1, 4'd11, 16'hFF36};
      prog[13] = '{"call_link", c_fmt(12'h010), 1, 4'd15, 16'h000E};
      prog[14] = '{"call_shadow", i_fmt(4'd12, 8'hEE), 0, 4'd12, 16'h00EE};
      prog[15] = '{"skipped", i_fmt(4'd13, 8'hDD), 0, 4'd13, 16'h00DD};
      prog[16] = '{"or_link", r_fmt(cpu_pkg::op_or, 4'd12, 4'd15, 4'd11), 1, 4'd12, 16'hFF3E};
      prog[17] = '{"add_self", r_fmt(cpu_pkg::op_add, 4'd13, 4'd12, 4'd12), 1, 4'd13, 16'hFE7C};
   endtask

   // ROM model and stall source, both ahead of the next rising edge
   always @(negedge clk) begin
      if (imem_addr < prog_len) begin
         instr <= prog[imem_addr].word;
      end else begin
         instr <= cpu_pkg::nop_word;        // Past the end
      end
      if (stall_en) begin
         mem_wait <= lfsr[0];               // One bit per cycle
         lfsr     <= lfsr_next(lfsr);
      end else begin
         mem_wait <= 1'b0;
      end
   end

   // Match one write-back against the next entry that writes
   task automatic check_writeback();
      while (exp_idx < prog_len && !prog[exp_idx].writes) begin
         exp_idx++;
      end
      seen++;
      if (exp_idx >= prog_len) begin
         $display("Run %0d: write-back to r%0d (%h) after the program ended",
                  run_no, wb_addr, wb_data);
         fail_cnt++;
      end else if (wb_addr !== prog[exp_idx].rd) begin
         $display("ERROR run %0d %s: wb_addr expected r%0d, actual r%0d",
                  run_no, prog[exp_idx].name, prog[exp_idx].rd, wb_addr);
         fail_cnt++;
      end else if (wb_data !== prog[exp_idx].value) begin
         $display("ERROR run %0d %s: wb_data expected %h, actual %h",
                  run_no, prog[exp_idx].name, prog[exp_idx].value, wb_data);
         fail_cnt++;
      end else begin
         $display("PASS  run %0d %s: r%0d = %h", run_no, prog[exp_idx].name, wb_addr, wb_data);
         pass_cnt++;
      end
      exp_idx++;
   endtask

   always @(posedge clk) begin
      if (wb_en === 1'b1) begin
         check_writeback();
      end
   end

   initial begin
      instr    = cpu_pkg::nop_word;
      mem_wait = 1'b0;
      load_program();
      for (int i = 0; i < prog_len; i++) begin
         if (prog[i].writes) begin
            exp_total++;
         end
      end
      wait (por_rst === 1'b0);

      // Run 1 with the memory always ready
      wait (seen >= exp_total);
      repeat (6) @(negedge clk);            // Room for a stray write-back

      // Run 2 from a fresh reset under random stalls
      @(negedge clk);
      rerun_rst = 1'b1;
      exp_idx   = 0;
      run_no    = 2;
      @(posedge clk);
      stall_en  = 1'b1;
      @(negedge clk);
      @(negedge clk);
      rerun_rst = 1'b0;
      wait (seen >= 2 * exp_total);
      repeat (6) @(negedge clk);

      $display("Write-backs: %0d passed, %0d failed, %0d assertion failures",
               pass_cnt, fail_cnt, uut.u_sva.assert_fails);
      if (fail_cnt == 0 && uut.u_sva.assert_fails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog sized from the program length
   initial begin
      #(watchdog_cycles * clk_period);
      $display("Timeout after %0d cycles: %0d of %0d write-backs seen, the rest are missing",
               watchdog_cycles, seen, 2 * exp_total);
      $display("sim failed");
      $finish;
   end

endmodule

// File: sources.f
cpu_pkg.sv
pipe_if.sv
fetch_unit.sv
ifid_reg.sv
decode_stage.sv
execute_stage.sv
cpu_top.sv
tb_clock.sv
cpu_sva.sv
cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - pipe_if.sv
  - fetch_unit.sv
  - ifid_reg.sv
  - decode_stage.sv
  - execute_stage.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - cpu_sva.sv
      - cpu_tb.sv
